//--- hdl/cdb_pkg.sv
// Completion subsystem shared definitions
// Bus width, unit counts, multiplier latency and the tag and state types
// used by the common data bus and the units that feed it

package cdb_pkg;

  // Broadcast lanes on the common data bus
  localparam int CDB_WIDTH = 2;

  // Functional unit counts
  localparam int NUM_FU_ALU  = 3;
  localparam int NUM_FU_MULT = 1;
  // ALUs take request lanes 0..NUM_FU_ALU-1, the multiplier follows them
  localparam int NUM_FU      = NUM_FU_ALU + NUM_FU_MULT;

  // Physical register file size and tag width
  localparam int PHYS_REGS = 32;
  localparam int TAG_W     = $clog2(PHYS_REGS);

  // Multiplier execution cycles
  localparam int MULT_LATENCY = 4;
  // Counter holds MULT_LATENCY-1 down to zero
  localparam int MULT_CNT_W   = (MULT_LATENCY > 1) ? $clog2(MULT_LATENCY) : 1;

  // Grant count covers 0..CDB_WIDTH
  localparam int GRANT_CNT_W = $clog2(CDB_WIDTH + 1);

  // Physical destination tag
  typedef logic [TAG_W-1:0] phys_tag_t;

  // Multiplier control states
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mult_state_t;

endpackage

//--- hdl/psel_gen.sv
// Multi-winner priority selector
// Grants up to CDB_WIDTH requests, one per bus lane, lowest index first

`timescale 1ns/1ns

module psel_gen import cdb_pkg::*; (
  input  logic [NUM_FU-1:0]                 req,
  output logic [CDB_WIDTH-1:0][NUM_FU-1:0]  gnt_bus
);

  // Each lane takes the lowest request that earlier lanes left over
  always_comb begin
    logic [NUM_FU-1:0] remaining;
    remaining = req;
    for (int lane = 0; lane < CDB_WIDTH; lane++) begin
      // Two's complement trick isolates the lowest set bit
      gnt_bus[lane] = remaining & (~remaining + 1'b1);
      // Winner is no longer eligible for later lanes
      remaining     = remaining & ~gnt_bus[lane];
    end
  end

  // Grants only go to requesting units
  always_comb begin
    for (int lane = 0; lane < CDB_WIDTH; lane++) begin
      assert final ((gnt_bus[lane] & ~req) == '0)
        else $error("psel_gen: lane %0d granted %b without request %b",
                    lane, gnt_bus[lane], req);
    end
  end

  // A unit wins at most one lane
  always_comb begin
    for (int a = 0; a < CDB_WIDTH; a++) begin
      for (int b = a + 1; b < CDB_WIDTH; b++) begin
        assert final ((gnt_bus[a] & gnt_bus[b]) == '0)
          else $error("psel_gen: lanes %0d and %0d share a winner", a, b);
      end
    end
  end

endmodule

//--- hdl/cdb.sv
// Tags-only common data bus
// Arbitrates unit requests onto CDB_WIDTH lanes, returns a registered
// grant mask one cycle later and broadcasts the winning tags the cycle after

`timescale 1ns/1ns

module cdb import cdb_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  // Requests from the units, cycle K
  input  logic      [NUM_FU-1:0]        fu_req_valid,
  input  phys_tag_t [NUM_FU-1:0]        fu_req_tag,
  // Winners back to the units, cycle K+1
  output logic      [NUM_FU-1:0]        ex_grant_mask_q,
  output logic      [GRANT_CNT_W-1:0]   ex_grant_count_q,
  // Broadcast, cycle K+2
  output logic      [CDB_WIDTH-1:0]     cdb_valid,
  output phys_tag_t [CDB_WIDTH-1:0]     cdb_tag
);

  logic [CDB_WIDTH-1:0][NUM_FU-1:0] lane_gnt;
  logic [CDB_WIDTH-1:0][NUM_FU-1:0] lane_gnt_q;
  logic [NUM_FU-1:0]                grant_mask_d;
  logic [GRANT_CNT_W-1:0]           grant_count_d;
  phys_tag_t [NUM_FU-1:0]           req_tag_q;
  logic [CDB_WIDTH-1:0]             lane_valid_d;
  phys_tag_t [CDB_WIDTH-1:0]        lane_tag_d;

  // One one-hot winner row per bus lane
  psel_gen i_psel_gen (
    .req     (fu_req_valid),
    .gnt_bus (lane_gnt)
  );

  // Fold lane rows into a per-unit mask and count the winners
  always_comb begin
    grant_mask_d  = '0;
    grant_count_d = '0;
    for (int lane = 0; lane < CDB_WIDTH; lane++) begin
      grant_mask_d |= lane_gnt[lane];
    end
    for (int fu = 0; fu < NUM_FU; fu++) begin
      grant_count_d += GRANT_CNT_W'(grant_mask_d[fu]);
    end
  end

  // Grant stage, aligned with the unit that must drop its request
  always_ff @(posedge clock) begin
    if (reset) begin
      lane_gnt_q       <= '0;
      ex_grant_mask_q  <= '0;
      ex_grant_count_q <= '0;
    end else begin
      lane_gnt_q       <= lane_gnt;
      ex_grant_mask_q  <= grant_mask_d;
      ex_grant_count_q <= grant_count_d;
    end
  end

  // Tags ride alongside the grants
  always_ff @(posedge clock) begin
    req_tag_q <= fu_req_tag;
  end

  // Per-lane one-hot tag mux
  always_comb begin
    for (int lane = 0; lane < CDB_WIDTH; lane++) begin
      lane_valid_d[lane] = |lane_gnt_q[lane];
      lane_tag_d[lane]   = '0;
      for (int fu = 0; fu < NUM_FU; fu++) begin
        if (lane_gnt_q[lane][fu]) begin
          lane_tag_d[lane] = req_tag_q[fu];
        end
      end
    end
  end

  // Broadcast register
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= '0;
    end else begin
      cdb_valid <= lane_valid_d;
    end
  end

  always_ff @(posedge clock) begin
    cdb_tag <= lane_tag_d;
  end

  // Count can never pass the number of lanes
  grant_count_bound: assert property (@(posedge clock) disable iff (reset)
    ex_grant_count_q <= GRANT_CNT_W'(CDB_WIDTH))
    else $error("cdb: grant count %0d above lane count", ex_grant_count_q);

endmodule

//--- hdl/fu_result_hold.sv
// ALU result hold
// One-entry register for a finished single-cycle result tag that
// requests the bus until granted and frees itself on the grant

`timescale 1ns/1ns

module fu_result_hold import cdb_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       issue_valid,
  input  phys_tag_t  issue_tag,
  input  logic       grant,
  output logic       req_valid,
  output phys_tag_t  req_tag,
  output logic       ready
);

  logic       full_q;
  phys_tag_t  tag_q;
  logic       take;

  // Free now, or freed by this cycle's grant
  assign ready = !full_q || grant;
  assign take  = issue_valid && ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (grant) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      tag_q <= issue_tag;
    end
  end

  // Masked in the grant cycle so the tag is not arbitrated twice
  assign req_valid = full_q && !grant;
  assign req_tag   = tag_q;

  // Issue only lands when the entry is free or leaving
  no_issue_when_full: assert property (@(posedge clock) disable iff (reset)
    issue_valid |-> (!full_q || grant))
    else $error("fu_result_hold: issue while holding tag %0d", tag_q);

endmodule

//--- hdl/mult_cycle_counter.sv
// Multiplier latency counter
// Counts MULT_LATENCY cycles after a load and flags the last one

`timescale 1ns/1ns

module mult_cycle_counter import cdb_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  load,
  output logic  done
);

  logic [MULT_CNT_W-1:0] count_q;
  logic                  running_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      running_q <= 1'b0;
      count_q   <= '0;
    end else if (load) begin
      running_q <= 1'b1;
      count_q   <= MULT_CNT_W'(MULT_LATENCY - 1);
    end else if (running_q) begin
      // Stops after the zero cycle
      if (count_q == '0) begin
        running_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // High in the last execution cycle
  assign done = running_q && (count_q == '0);

  no_reload_while_running: assert property (@(posedge clock) disable iff (reset)
    load |-> !running_q)
    else $error("mult_cycle_counter: load with %0d cycles left", count_q);

endmodule

//--- hdl/mult_ctrl.sv
// Multiplier control
// IDLE/BUSY/DONE machine that runs one multiply for MULT_LATENCY cycles,
// then holds its tag and requests the bus until granted

`timescale 1ns/1ns

module mult_ctrl import cdb_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       issue_valid,
  input  phys_tag_t  issue_tag,
  input  logic       grant,
  output logic       req_valid,
  output phys_tag_t  req_tag,
  output logic       ready
);

  mult_state_t state_q;
  mult_state_t state_d;
  phys_tag_t   tag_q;
  logic        start;
  logic        cnt_done;

  // Accepts only when idle
  assign ready = (state_q == IDLE);
  assign start = issue_valid && ready;

  mult_cycle_counter i_mult_cycle_counter (
    .clock (clock),
    .reset (reset),
    .load  (start),
    .done  (cnt_done)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = BUSY;
      // Last execution cycle moves to DONE
      BUSY:    if (cnt_done) state_d = DONE;
      // Result leaves on its grant
      DONE:    if (grant) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Destination tag latched at issue
  always_ff @(posedge clock) begin
    if (start) begin
      tag_q <= issue_tag;
    end
  end

  // Request dropped in the grant cycle
  assign req_valid = (state_q == DONE) && !grant;
  assign req_tag   = tag_q;

endmodule

//--- hdl/ready_table.sv
// Physical register ready table
// One bit per physical register, cleared when rename allocates the
// register and set when the bus broadcasts its tag

`timescale 1ns/1ns

module ready_table import cdb_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatch_valid,
  input  phys_tag_t                  dispatch_tag,
  input  logic      [CDB_WIDTH-1:0]  cdb_valid,
  input  phys_tag_t [CDB_WIDTH-1:0]  cdb_tag,
  output logic      [PHYS_REGS-1:0]  ready_bits
);

  logic [PHYS_REGS-1:0] ready_d;

  always_comb begin
    ready_d = ready_bits;
    // Newly allocated destination is not ready
    if (dispatch_valid) begin
      ready_d[dispatch_tag] = 1'b0;
    end
    // Broadcast applied last so set beats clear
    for (int lane = 0; lane < CDB_WIDTH; lane++) begin
      if (cdb_valid[lane]) begin
        ready_d[cdb_tag[lane]] = 1'b1;
      end
    end
  end

  // Out of reset every register holds architectural state
  always_ff @(posedge clock) begin
    if (reset) begin
      ready_bits <= '1;
    end else begin
      ready_bits <= ready_d;
    end
  end

  // A completing tag must have been allocated first
  for (genvar lane = 0; lane < CDB_WIDTH; lane++) begin : g_bcast_chk
    bcast_not_ready: assert property (@(posedge clock) disable iff (reset)
      cdb_valid[lane] |-> !ready_bits[cdb_tag[lane]])
      else $error("ready_table: lane %0d broadcast tag %0d already ready",
                  lane, cdb_tag[lane]);
  end

endmodule

//--- hdl/completion_top.sv
// Completion subsystem top
// ALU and multiplier result units feeding the common data bus, whose
// broadcast updates the physical register ready table

`timescale 1ns/1ns

module completion_top import cdb_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  // Issue from the execute stage
  input  logic      [NUM_FU_ALU-1:0]   alu_issue_valid,
  input  phys_tag_t [NUM_FU_ALU-1:0]   alu_issue_tag,
  input  logic                         mult_issue_valid,
  input  phys_tag_t                    mult_issue_tag,
  // Rename allocation
  input  logic                         dispatch_valid,
  input  phys_tag_t                    dispatch_tag,
  // Unit ready levels
  output logic      [NUM_FU_ALU-1:0]   alu_ready,
  output logic                         mult_ready,
  // Broadcast and bus status
  output logic      [CDB_WIDTH-1:0]    cdb_valid,
  output phys_tag_t [CDB_WIDTH-1:0]    cdb_tag,
  output logic      [GRANT_CNT_W-1:0]  grant_count,
  output logic      [PHYS_REGS-1:0]    ready_bits
);

  logic      [NUM_FU-1:0]  fu_req_valid;
  phys_tag_t [NUM_FU-1:0]  fu_req_tag;
  logic      [NUM_FU-1:0]  ex_grant_mask_q;

  // ALU lanes occupy the low request indices
  for (genvar g = 0; g < NUM_FU_ALU; g++) begin : g_alu
    fu_result_hold i_fu_result_hold (
      .clock       (clock),
      .reset       (reset),
      .issue_valid (alu_issue_valid[g]),
      .issue_tag   (alu_issue_tag[g]),
      .grant       (ex_grant_mask_q[g]),
      .req_valid   (fu_req_valid[g]),
      .req_tag     (fu_req_tag[g]),
      .ready       (alu_ready[g])
    );
  end

  // Multiplier takes the lowest priority lane
  mult_ctrl i_mult_ctrl (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (mult_issue_valid),
    .issue_tag   (mult_issue_tag),
    .grant       (ex_grant_mask_q[NUM_FU_ALU]),
    .req_valid   (fu_req_valid[NUM_FU_ALU]),
    .req_tag     (fu_req_tag[NUM_FU_ALU]),
    .ready       (mult_ready)
  );

  cdb i_cdb (
    .clock            (clock),
    .reset            (reset),
    .fu_req_valid     (fu_req_valid),
    .fu_req_tag       (fu_req_tag),
    .ex_grant_mask_q  (ex_grant_mask_q),
    .ex_grant_count_q (grant_count),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag)
  );

  ready_table i_ready_table (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_tag   (dispatch_tag),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .ready_bits     (ready_bits)
  );

endmodule

//--- verification/completion_tb.sv
// Completion subsystem testbench
// Table-driven issue stimulus with a cycle model of the units, bus
// arbitration and ready table that predicts every broadcast

`timescale 1ns/1ns

module completion_tb import cdb_pkg::*; ();

  localparam int NUM_ROWS        = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + RESET_CYCLES;

  logic                        clock;
  logic                        reset;
  logic      [NUM_FU_ALU-1:0]  alu_issue_valid;
  phys_tag_t [NUM_FU_ALU-1:0]  alu_issue_tag;
  logic                        mult_issue_valid;
  phys_tag_t                   mult_issue_tag;
  logic                        dispatch_valid;
  phys_tag_t                   dispatch_tag;
  logic      [NUM_FU_ALU-1:0]  alu_ready;
  logic                        mult_ready;
  logic      [CDB_WIDTH-1:0]   cdb_valid;
  phys_tag_t [CDB_WIDTH-1:0]   cdb_tag;
  logic      [GRANT_CNT_W-1:0] grant_count;
  logic      [PHYS_REGS-1:0]   ready_bits;

  // Stimulus table: idle gap, ALU issue mask, multiplier issue, tag base
  int         row_gap  [NUM_ROWS] = '{2, 1, 1, 0, 0, 1, 0, 2, 0, 1};
  logic [2:0] row_alu  [NUM_ROWS] = '{3'b001, 3'b000, 3'b010, 3'b111, 3'b111,
                                      3'b101, 3'b100, 3'b011, 3'b110, 3'b111};
  logic       row_mult [NUM_ROWS] = '{0, 1, 0, 0, 1, 1, 0, 1, 0, 1};
  int         row_base [NUM_ROWS] = '{1, 4, 6, 8, 12, 16, 20, 24, 28, 2};

  // Model of the units, the bus pipeline and the ready table
  logic      [NUM_FU_ALU-1:0] m_full;
  phys_tag_t [NUM_FU-1:0]     m_tag;
  mult_state_t                m_mstate;
  int                         m_mcnt;
  logic      [NUM_FU-1:0]     m_gm;
  int                         m_gcnt;
  logic      [CDB_WIDTH-1:0]  m_lane_v;
  phys_tag_t [CDB_WIDTH-1:0]  m_lane_tag;
  logic      [CDB_WIDTH-1:0]  m_bc_v;
  phys_tag_t [CDB_WIDTH-1:0]  m_bc_tag;
  logic      [PHYS_REGS-1:0]  m_rdy;

  // Scoreboard
  logic [PHYS_REGS-1:0] in_flight;
  int                   issue_cycle [PHYS_REGS];
  int                   lat_expect  [PHYS_REGS];
  int                   cycle;
  int                   errors;
  int                   checks;
  logic                 checks_on;
  logic [31:0]          lfsr;
  phys_tag_t            hit_tag;

  completion_top i_dut (
    .clock            (clock),
    .reset            (reset),
    .alu_issue_valid  (alu_issue_valid),
    .alu_issue_tag    (alu_issue_tag),
    .mult_issue_valid (mult_issue_valid),
    .mult_issue_tag   (mult_issue_tag),
    .dispatch_valid   (dispatch_valid),
    .dispatch_tag     (dispatch_tag),
    .alu_ready        (alu_ready),
    .mult_ready       (mult_ready),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag),
    .grant_count      (grant_count),
    .ready_bits       (ready_bits)
  );

  always #2 clock = ~clock;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // Random offset from the base, skipping tags still pending
  task automatic pick_tag(input int base, output phys_tag_t t);
    int off;
    take_bits(3, off);
    t = phys_tag_t'((base + off) % PHYS_REGS);
    while (in_flight[t]) begin
      t = t + 1'b1;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
  endtask

  // Unit requests: held result not being granted this cycle
  function automatic logic [NUM_FU-1:0] model_req();
    logic [NUM_FU-1:0] r;
    r[NUM_FU_ALU-1:0] = m_full & ~m_gm[NUM_FU_ALU-1:0];
    r[NUM_FU_ALU]     = (m_mstate == DONE) && !m_gm[NUM_FU_ALU];
    return r;
  endfunction

  task automatic model_reset();
    m_full   = '0;
    m_mstate = IDLE;
    m_mcnt   = 0;
    m_gm     = '0;
    m_gcnt   = 0;
    m_lane_v = '0;
    m_bc_v   = '0;
    m_rdy    = '1;
  endtask

  // One clock edge of the model, from current state and applied inputs
  task automatic model_step();
    logic      [NUM_FU-1:0]    req;
    logic      [NUM_FU-1:0]    new_gm;
    logic      [CDB_WIDTH-1:0] new_v;
    phys_tag_t [CDB_WIDTH-1:0] new_tag;
    int                        lane;
    req     = model_req();
    new_gm  = '0;
    new_v   = '0;
    new_tag = '0;
    lane    = 0;
    // Lowest unit index takes the lowest free lane
    for (int u = 0; u < NUM_FU; u++) begin
      if (req[u] && lane < CDB_WIDTH) begin
        new_gm[u]     = 1'b1;
        new_v[lane]   = 1'b1;
        new_tag[lane] = m_tag[u];
        lane++;
      end
    end
    // Set after clear, so a broadcast wins
    if (dispatch_valid) begin
      m_rdy[dispatch_tag] = 1'b0;
    end
    for (int l = 0; l < CDB_WIDTH; l++) begin
      if (m_bc_v[l]) begin
        m_rdy[m_bc_tag[l]] = 1'b1;
      end
    end
    m_bc_v   = m_lane_v;
    m_bc_tag = m_lane_tag;
    for (int i = 0; i < NUM_FU_ALU; i++) begin
      if (alu_issue_valid[i] && (!m_full[i] || m_gm[i])) begin
        m_full[i] = 1'b1;
        m_tag[i]  = alu_issue_tag[i];
      end else if (m_gm[i]) begin
        m_full[i] = 1'b0;
      end
    end
    case (m_mstate)
      IDLE: begin
        if (mult_issue_valid) begin
          m_mstate           = BUSY;
          m_mcnt             = MULT_LATENCY;
          m_tag[NUM_FU_ALU]  = mult_issue_tag;
        end
      end
      BUSY: begin
        if (m_mcnt == 1) begin
          m_mstate = DONE;
        end else begin
          m_mcnt--;
        end
      end
      default: begin
        if (m_gm[NUM_FU_ALU]) begin
          m_mstate = IDLE;
        end
      end
    endcase
    m_gm       = new_gm;
    m_gcnt     = lane;
    m_lane_v   = new_v;
    m_lane_tag = new_tag;
  endtask

  task automatic next_cycle();
    @(posedge clock);
    if (reset) begin
      model_reset();
    end else begin
      model_step();
    end
    cycle++;
  endtask

  // Outputs compared mid-cycle, where they are settled
  task automatic compare_outputs();
    logic [NUM_FU_ALU-1:0] exp_alu_ready;
    phys_tag_t             t;
    exp_alu_ready = ~m_full | m_gm[NUM_FU_ALU-1:0];
    checks += 5;
    if (alu_ready !== exp_alu_ready) begin
      report_mismatch("alu_ready", alu_ready, exp_alu_ready);
    end
    if (mult_ready !== (m_mstate == IDLE)) begin
      report_mismatch("mult_ready", mult_ready, m_mstate == IDLE);
    end
    if (grant_count !== GRANT_CNT_W'(m_gcnt)) begin
      report_mismatch("grant_count", grant_count, m_gcnt);
    end
    if (cdb_valid !== m_bc_v) begin
      report_mismatch("cdb_valid", cdb_valid, m_bc_v);
    end
    if (ready_bits !== m_rdy) begin
      report_mismatch("ready_bits", ready_bits, m_rdy);
    end
    for (int l = 0; l < CDB_WIDTH; l++) begin
      if (cdb_valid[l] === 1'b1) begin
        t = cdb_tag[l];
        checks++;
        if (cdb_tag[l] !== m_bc_tag[l]) begin
          report_mismatch($sformatf("cdb_tag[%0d]", l), cdb_tag[l], m_bc_tag[l]);
        end
        // Each tag leaves the scoreboard on its one broadcast
        if (in_flight[t] !== 1'b1) begin
          errors++;
          $display("Tag %0d broadcast on lane %0d at %0t with no result pending",
                   t, l, $time);
        end else begin
          in_flight[t] = 1'b0;
          if (lat_expect[t] != 0 && cycle - issue_cycle[t] != lat_expect[t]) begin
            report_mismatch($sformatf("latency of tag %0d", t),
                            cycle - issue_cycle[t], lat_expect[t]);
          end
        end
      end
    end
  endtask

  always @(negedge clock) begin
    if (checks_on) begin
      compare_outputs();
    end
  end

  // Drain, dispatch each tag, then issue so that all requests coincide
  task automatic run_row(input int r);
    logic      [NUM_FU-1:0] use_unit;
    phys_tag_t [NUM_FU-1:0] tags;
    int                     gap;
    int                     n_issue;
    use_unit = {row_mult[r], row_alu[r]};
    n_issue  = $countones(use_unit);
    tags     = '0;
    while (in_flight != '0) begin
      next_cycle();
    end
    take_bits(2, gap);
    repeat (row_gap[r] + gap) next_cycle();
    for (int u = 0; u < NUM_FU; u++) begin
      if (use_unit[u]) begin
        pick_tag(row_base[r], tags[u]);
        in_flight[tags[u]] = 1'b1;
        lat_expect[tags[u]] = 0;
        // Lone issues have a fixed latency
        if (n_issue == 1) begin
          lat_expect[tags[u]] = (u == NUM_FU_ALU) ? MULT_LATENCY + 3 : 3;
        end
        dispatch_valid <= 1'b1;
        dispatch_tag   <= tags[u];
        next_cycle();
      end
    end
    dispatch_valid <= 1'b0;
    if (row_mult[r]) begin
      mult_issue_valid <= 1'b1;
      mult_issue_tag   <= tags[NUM_FU_ALU];
      issue_cycle[tags[NUM_FU_ALU]] = cycle;
      next_cycle();
      mult_issue_valid <= 1'b0;
      // ALUs follow so their requests meet the multiplier's
      if (row_alu[r] != '0) begin
        repeat (MULT_LATENCY - 1) next_cycle();
      end
    end
    if (row_alu[r] != '0) begin
      alu_issue_valid <= row_alu[r];
      for (int i = 0; i < NUM_FU_ALU; i++) begin
        alu_issue_tag[i] <= tags[i];
        issue_cycle[tags[i]] = cycle;
      end
      next_cycle();
      alu_issue_valid <= '0;
    end
  endtask

  initial begin
    clock            = 1'b0;
    reset            = 1'b1;
    alu_issue_valid  = '0;
    alu_issue_tag    = '0;
    mult_issue_valid = 1'b0;
    mult_issue_tag   = '0;
    dispatch_valid   = 1'b0;
    dispatch_tag     = '0;
    lfsr             = 32'h3122_2089;
    in_flight        = '0;
    errors           = 0;
    checks           = 0;
    cycle            = 0;
    checks_on        = 1'b0;
    for (int i = 0; i < PHYS_REGS; i++) begin
      lat_expect[i]  = 0;
      issue_cycle[i] = 0;
    end
    model_reset();
    repeat (RESET_CYCLES) next_cycle();
    reset     <= 1'b0;
    checks_on  = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    // Redispatch of a tag in the very cycle it is broadcast
    while (in_flight != '0) begin
      next_cycle();
    end
    pick_tag(9, hit_tag);
    in_flight[hit_tag]  = 1'b1;
    lat_expect[hit_tag] = 3;
    dispatch_valid <= 1'b1;
    dispatch_tag   <= hit_tag;
    next_cycle();
    dispatch_valid     <= 1'b0;
    alu_issue_valid    <= 3'b001;
    alu_issue_tag[0]   <= hit_tag;
    issue_cycle[hit_tag] = cycle;
    next_cycle();
    alu_issue_valid <= '0;
    while (!(m_bc_v[0] && m_bc_tag[0] == hit_tag)) begin
      next_cycle();
    end
    dispatch_valid <= 1'b1;
    dispatch_tag   <= hit_tag;
    next_cycle();
    dispatch_valid <= 1'b0;
    @(negedge clock);
    checks++;
    if (ready_bits[hit_tag] !== 1'b1) begin
      report_mismatch($sformatf("ready_bits[%0d]", hit_tag), ready_bits[hit_tag], 1'b1);
    end
    repeat (4) next_cycle();
    $display("Completion run: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- verilog.f
hdl/cdb_pkg.sv
hdl/psel_gen.sv
hdl/cdb.sv
hdl/fu_result_hold.sv
hdl/mult_cycle_counter.sv
hdl/mult_ctrl.sv
hdl/ready_table.sv
hdl/completion_top.sv
verification/completion_tb.sv
